// File: bench/la_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module la_core_tb;

    localparam int clk_period = 4;

    logic        clk;
    logic        rst;
    logic        req;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        ack;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        br_taken;
    logic [31:0] br_target;
    logic        illegal;

    // Shadow register file
    logic [31:0] model [32];
    logic [31:0] lcg_state = 32'ha785_19f1;
    int          issued = 0;

    logic        got_wb_en;
    logic [4:0]  got_wb_addr;
    logic [31:0] got_wb_data;
    logic        got_br_taken;
    logic [31:0] got_br_target;
    logic        got_illegal;

    la_core dut (
        .clk(clk), .rst(rst), .req(req), .inst(inst), .pc(pc), .ack(ack),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .br_taken(br_taken), .br_target(br_target), .illegal(illegal)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // Deadline grows with every issued instruction
    initial begin
        while ($time <= 1000 + 200 * clk_period * issued) begin
            @(posedge clk);
        end
        $display("Handshake timed out: an instruction got no ack before the run deadline");
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired");
    end

    ////////////////////
    // Helpers

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rk,
                                           input logic [4:0] rj, input logic [4:0] rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_ri12(input logic [9:0] op, input logic [11:0] imm,
                                             input logic [4:0] rj, input logic [4:0] rd);
        return {op, imm, rj, rd};
    endfunction

    function automatic logic [31:0] enc_ri20(input logic [6:0] op, input logic [19:0] imm,
                                             input logic [4:0] rd);
        return {op, imm, rd};
    endfunction

    function automatic logic [31:0] enc_ri16(input logic [5:0] op, input logic [15:0] offs,
                                             input logic [4:0] rj, input logic [4:0] rd);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i26(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    // Order add sub slt sltu and or nor xor sll srl sra
    function automatic logic [16:0] rr_opcode(input int idx);
        case (idx)
            0: return 17'h00020;
            1: return 17'h00022;
            2: return 17'h00024;
            3: return 17'h00025;
            4: return 17'h00029;
            5: return 17'h0002a;
            6: return 17'h00028;
            7: return 17'h0002b;
            8: return 17'h0002e;
            9: return 17'h0002f;
            default: return 17'h00030;
        endcase
    endfunction

    function automatic logic [31:0] alu_ref(input int idx, input logic [31:0] a,
                                            input logic [31:0] b);
        case (idx)
            0: return a + b;
            1: return a - b;
            2: return {31'd0, $signed(a) < $signed(b)};
            3: return {31'd0, a < b};
            4: return a & b;
            5: return a | b;
            6: return ~(a | b);
            7: return a ^ b;
            8: return a << b[4:0];
            9: return a >> b[4:0];
            default: return $signed(a) >>> b[4:0];
        endcase
    endfunction

    // Order beq bne blt bge bltu bgeu as in opcodes 0x16 upward
    function automatic logic branch_ref(input int idx, input logic [31:0] a,
                                        input logic [31:0] b);
        case (idx)
            0: return a == b;
            1: return a != b;
            2: return $signed(a) < $signed(b);
            3: return $signed(a) >= $signed(b);
            4: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic report_failure(input string msg);
        $display("Error: at %0t ns: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else report_failure($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic issue_inst(input logic [31:0] word, input logic [31:0] addr,
                              input int hold);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        inst = word;
        pc = addr;
        req = 1'b1;
        issued++;
        while (!ack) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        check_value("ack latency in edges", cycles, 3);
        repeat (hold) begin
            @(posedge clk);
            #1;
            check_value("ack while req held", ack, 1);
        end
        got_wb_en = wb_en;
        got_wb_addr = wb_addr;
        got_wb_data = wb_data;
        got_br_taken = br_taken;
        got_br_target = br_target;
        got_illegal = illegal;
        req = 1'b0;
        @(posedge clk);
        #1;
        check_value("ack after req drop", ack, 0);
    endtask

    task automatic expect_write(input logic [31:0] word, input logic [31:0] addr,
                                input logic [4:0] rd, input logic [31:0] value);
        issue_inst(word, addr, 0);
        check_value("illegal", got_illegal, 0);
        check_value("br_taken", got_br_taken, 0);
        check_value("wb_en", got_wb_en, rd != 0);
        if (rd != 0) begin
            check_value("wb_addr", got_wb_addr, rd);
            check_value("wb_data", got_wb_data, value);
            model[rd] = value;
        end
    endtask

    task automatic expect_branch(input logic [31:0] word, input logic [31:0] addr,
                                 input logic taken, input logic [31:0] target,
                                 input logic [4:0] link_rd, input logic [31:0] link_val);
        issue_inst(word, addr, 0);
        check_value("illegal", got_illegal, 0);
        check_value("br_taken", got_br_taken, taken);
        check_value("br_target", got_br_target, target);
        check_value("wb_en", got_wb_en, link_rd != 0);
        if (link_rd != 0) begin
            check_value("wb_addr", got_wb_addr, link_rd);
            check_value("wb_data", got_wb_data, link_val);
            model[link_rd] = link_val;
        end
    endtask

    // lu12i then addi with rounding for the sign of the low part
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = (value + 32'h800) >> 12;
        expect_write(enc_ri20(7'h0a, hi[19:0], rd), 32'h1000, rd, {hi[19:0], 12'd0});
        expect_write(enc_ri12(10'h00a, value[11:0], rd, rd), 32'h1004, rd,
                     model[rd] + {{20{value[11]}}, value[11:0]});
    endtask

    ////////////////////
    // Tests

    task automatic reset_handshake_test();
        check_value("ack after reset", ack, 0);
        check_value("wb_en after reset", wb_en, 0);
        check_value("illegal after reset", illegal, 0);
        // add r9, r5, r6 with req held three extra cycles
        issue_inst(enc_3r(17'h00020, 5'd6, 5'd5, 5'd9), 32'h100, 3);
        check_value("wb_en", got_wb_en, 1);
        check_value("wb_data from cleared regs", got_wb_data, 0);
        model[9] = 32'h0;
    endtask

    task automatic reg_alu_test();
        for (int r = 5; r <= 8; r++) begin
            load_reg(r[4:0], next_rand());
        end
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < 11; i++) begin
                expect_write(enc_3r(rr_opcode(i), 6 + 2 * p, 5 + 2 * p, 10 + i), 32'h2000,
                             10 + i, alu_ref(i, model[5 + 2 * p], model[6 + 2 * p]));
            end
        end
        expect_write(enc_3r(17'h00020, 5'd6, 5'd5, 5'd0), 32'h2000, 5'd0, 32'h0);
        expect_write(enc_3r(17'h00020, 5'd5, 5'd0, 5'd9), 32'h2000, 5'd9, model[5]);
    endtask

    task automatic imm_test();
        logic [31:0] a;
        logic [31:0] r;
        logic [31:0] sx;
        logic [31:0] ux;
        logic [31:0] pcv;
        logic [4:0]  rj;
        logic [4:0]  sh;
        for (int it = 0; it < 2; it++) begin
            rj = 5'd5 + 5'(2 * it);
            a = model[rj];
            r = next_rand();
            sx = {{20{r[11]}}, r[11:0]};
            ux = {20'd0, r[11:0]};
            sh = r[16:12];
            expect_write(enc_ri12(10'h00a, r[11:0], rj, 5'd12), 32'h3000, 5'd12, a + sx);
            expect_write(enc_ri12(10'h008, r[11:0], rj, 5'd13), 32'h3000, 5'd13,
                         $signed(a) < $signed(sx));
            expect_write(enc_ri12(10'h009, r[11:0], rj, 5'd14), 32'h3000, 5'd14, a < sx);
            expect_write(enc_ri12(10'h00d, r[11:0], rj, 5'd15), 32'h3000, 5'd15, a & ux);
            expect_write(enc_ri12(10'h00e, r[11:0], rj, 5'd16), 32'h3000, 5'd16, a | ux);
            expect_write(enc_ri12(10'h00f, r[11:0], rj, 5'd17), 32'h3000, 5'd17, a ^ ux);
            expect_write(enc_3r(17'h00081, sh, rj, 5'd18), 32'h3000, 5'd18, a << sh);
            expect_write(enc_3r(17'h00089, sh, rj, 5'd19), 32'h3000, 5'd19, a >> sh);
            expect_write(enc_3r(17'h00091, sh, rj, 5'd20), 32'h3000, 5'd20,
                         $signed(a) >>> sh);
            r = next_rand();
            pcv = next_rand() & ~32'h3;
            expect_write(enc_ri20(7'h0a, r[19:0], 5'd21), pcv, 5'd21, {r[19:0], 12'd0});
            expect_write(enc_ri20(7'h0e, r[19:0], 5'd22), pcv, 5'd22,
                         pcv + {r[19:0], 12'd0});
        end
    endtask

    task automatic branch_test();
        logic [31:0] v;
        logic [31:0] r;
        logic [31:0] pcv;
        logic [4:0]  rj;
        logic [4:0]  rd;
        v = next_rand();
        load_reg(5'd20, v);
        load_reg(5'd21, v);
        // r22 negative and r23 positive so signed and unsigned order disagree
        load_reg(5'd22, v | 32'h8000_0000);
        load_reg(5'd23, next_rand() & 32'h7fff_ffff);
        for (int p = 0; p < 3; p++) begin
            rj = (p == 0) ? 5'd20 : (p == 1) ? 5'd22 : 5'd23;
            rd = (p == 0) ? 5'd21 : (p == 1) ? 5'd23 : 5'd22;
            for (int k = 0; k < 6; k++) begin
                r = next_rand();
                pcv = next_rand() & ~32'h3;
                expect_branch(enc_ri16(6'h16 + 6'(k), r[15:0], rj, rd), pcv,
                              branch_ref(k, model[rj], model[rd]),
                              pcv + {{14{r[15]}}, r[15:0], 2'b00}, 5'd0, 32'h0);
            end
        end
    endtask

    task automatic jump_test();
        logic [31:0] r;
        logic [31:0] pcv;
        r = next_rand();
        pcv = next_rand() & ~32'h3;
        expect_branch(enc_i26(6'h14, r[25:0]), pcv, 1'b1,
                      pcv + {{4{r[25]}}, r[25:0], 2'b00}, 5'd0, 32'h0);
        r = next_rand();
        pcv = next_rand() & ~32'h3;
        expect_branch(enc_i26(6'h15, r[25:0]), pcv, 1'b1,
                      pcv + {{4{r[25]}}, r[25:0], 2'b00}, 5'd1, pcv + 32'd4);
        r = next_rand();
        pcv = next_rand() & ~32'h3;
        expect_branch(enc_ri16(6'h13, r[15:0], 5'd5, 5'd3), pcv, 1'b1,
                      model[5] + {{14{r[15]}}, r[15:0], 2'b00}, 5'd3, pcv + 32'd4);
        expect_write(enc_3r(17'h00020, 5'd3, 5'd1, 5'd9), 32'h4000, 5'd9,
                     model[1] + model[3]);
    endtask

    task automatic illegal_test();
        logic [31:0] words [3];
        // ld.w r6, st.w r6, then an unassigned word
        words[0] = enc_ri12(10'h0a2, 12'h010, 5'd5, 5'd6);
        words[1] = enc_ri12(10'h0a6, 12'h020, 5'd5, 5'd6);
        words[2] = 32'hffff_ffff;
        for (int i = 0; i < 3; i++) begin
            issue_inst(words[i], 32'h5000, 0);
            check_value("illegal", got_illegal, 1);
            check_value("wb_en", got_wb_en, 0);
            check_value("br_taken", got_br_taken, 0);
        end
        expect_write(enc_3r(17'h00020, 5'd31, 5'd6, 5'd9), 32'h5000, 5'd9,
                     model[6] + model[31]);
    endtask

    initial begin
        rst = 1'b1;
        req = 1'b0;
        inst = 32'h0;
        pc = 32'h0;
        for (int i = 0; i < 32; i++) begin
            model[i] = 32'h0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_handshake_test();
        reg_alu_test();
        imm_test();
        branch_test();
        jump_test();
        illegal_test();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/la_core.sv
`timescale 1ns/1ps
`default_nettype none

module la_core (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           req,
    input  wire  [la_pkg::xlen-1:0]       inst,
    input  wire  [la_pkg::xlen-1:0]       pc,
    output logic                          ack,
    output logic                          wb_en,
    output logic [la_pkg::reg_addr_w-1:0] wb_addr,
    output logic [la_pkg::xlen-1:0]       wb_data,
    output logic                          br_taken,
    output logic [la_pkg::xlen-1:0]       br_target,
    output logic                          illegal
);

    logic                          exec_en;
    logic [la_pkg::xlen-1:0]       inst_q;
    logic [la_pkg::xlen-1:0]       pc_q;
    la_pkg::alu_op_e               alu_op;
    la_pkg::br_type_e              br_type;
    la_pkg::src1_sel_e             src1_sel;
    la_pkg::src2_sel_e             src2_sel;
    logic [la_pkg::xlen-1:0]       imm;
    logic [la_pkg::reg_addr_w-1:0] rs1;
    logic [la_pkg::reg_addr_w-1:0] rs2;
    logic [la_pkg::reg_addr_w-1:0] rd;
    logic                          dec_wb_en;
    logic                          dec_illegal;
    logic [la_pkg::xlen-1:0]       rdata1;
    logic [la_pkg::xlen-1:0]       rdata2;
    logic [la_pkg::xlen-1:0]       alu_result;
    logic                          ex_br_taken;
    logic [la_pkg::xlen-1:0]       ex_br_target;
    logic                          rf_we;
    logic [la_pkg::reg_addr_w-1:0] rf_waddr;
    logic [la_pkg::xlen-1:0]       rf_wdata;

    la_issue_ctrl u_issue (
        .clk(clk), .rst(rst), .req(req), .inst(inst), .pc(pc),
        .ack(ack), .exec_en(exec_en), .inst_q(inst_q), .pc_q(pc_q)
    );

    la_decode u_decode (
        .inst(inst_q), .alu_op(alu_op), .br_type(br_type),
        .src1_sel(src1_sel), .src2_sel(src2_sel), .imm(imm),
        .rs1(rs1), .rs2(rs2), .rd(rd), .wb_en(dec_wb_en), .illegal(dec_illegal)
    );

    la_regfile u_regfile (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2),
        .rdata1(rdata1), .rdata2(rdata2),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    la_execute u_execute (
        .pc(pc_q), .rdata1(rdata1), .rdata2(rdata2), .imm(imm),
        .alu_op(alu_op), .br_type(br_type), .src1_sel(src1_sel), .src2_sel(src2_sel),
        .alu_result(alu_result), .br_taken(ex_br_taken), .br_target(ex_br_target)
    );

    la_result u_result (
        .clk(clk), .rst(rst), .exec_en(exec_en), .alu_result(alu_result),
        .br_taken_in(ex_br_taken), .br_target_in(ex_br_target), .rd(rd),
        .wb_en_in(dec_wb_en), .illegal_in(dec_illegal),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .br_taken(br_taken), .br_target(br_target), .illegal(illegal),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata)
    );

endmodule

`default_nettype wire

// File: hw/la_decode.sv
`timescale 1ns/1ps
`default_nettype none

module la_decode (
    input  wire  [la_pkg::xlen-1:0]       inst,
    output la_pkg::alu_op_e               alu_op,
    output la_pkg::br_type_e              br_type,
    output la_pkg::src1_sel_e             src1_sel,
    output la_pkg::src2_sel_e             src2_sel,
    output logic [la_pkg::xlen-1:0]       imm,
    output logic [la_pkg::reg_addr_w-1:0] rs1,
    output logic [la_pkg::reg_addr_w-1:0] rs2,
    output logic [la_pkg::reg_addr_w-1:0] rd,
    output logic                          wb_en,
    output logic                          illegal
);

    ////////////////////
    // Opcode match

    wire add_inst       = (inst[31:15] == 17'h00020);
    wire sub_inst       = (inst[31:15] == 17'h00022);
    wire slt_inst       = (inst[31:15] == 17'h00024);
    wire sltu_inst      = (inst[31:15] == 17'h00025);
    wire nor_inst       = (inst[31:15] == 17'h00028);
    wire and_inst       = (inst[31:15] == 17'h00029);
    wire or_inst        = (inst[31:15] == 17'h0002a);
    wire xor_inst       = (inst[31:15] == 17'h0002b);
    wire sll_inst       = (inst[31:15] == 17'h0002e);
    wire srl_inst       = (inst[31:15] == 17'h0002f);
    wire sra_inst       = (inst[31:15] == 17'h00030);
    wire slli_inst      = (inst[31:15] == 17'h00081);
    wire srli_inst      = (inst[31:15] == 17'h00089);
    wire srai_inst      = (inst[31:15] == 17'h00091);
    wire slti_inst      = (inst[31:22] == 10'h008);
    wire sltui_inst     = (inst[31:22] == 10'h009);
    wire addi_inst      = (inst[31:22] == 10'h00a);
    wire andi_inst      = (inst[31:22] == 10'h00d);
    wire ori_inst       = (inst[31:22] == 10'h00e);
    wire xori_inst      = (inst[31:22] == 10'h00f);
    wire lu12i_inst     = (inst[31:25] == 7'h0a);
    wire pcaddu12i_inst = (inst[31:25] == 7'h0e);
    wire jirl_inst      = (inst[31:26] == 6'h13);
    wire b_inst         = (inst[31:26] == 6'h14);
    wire bl_inst        = (inst[31:26] == 6'h15);
    wire beq_inst       = (inst[31:26] == 6'h16);
    wire bne_inst       = (inst[31:26] == 6'h17);
    wire blt_inst       = (inst[31:26] == 6'h18);
    wire bge_inst       = (inst[31:26] == 6'h19);
    wire bltu_inst      = (inst[31:26] == 6'h1a);
    wire bgeu_inst      = (inst[31:26] == 6'h1b);

    wire is_3r   = add_inst | sub_inst | slt_inst | sltu_inst | nor_inst | and_inst |
                   or_inst | xor_inst | sll_inst | srl_inst | sra_inst;
    wire is_si12 = addi_inst | slti_inst | sltui_inst;
    wire is_ui12 = andi_inst | ori_inst | xori_inst;
    wire is_shi  = slli_inst | srli_inst | srai_inst;
    wire is_u12i = lu12i_inst | pcaddu12i_inst;
    wire is_cond = beq_inst | bne_inst | blt_inst | bge_inst | bltu_inst | bgeu_inst;
    wire legal   = is_3r | is_si12 | is_ui12 | is_shi | is_u12i | is_cond |
                   b_inst | bl_inst | jirl_inst;

    assign illegal = ~legal;
    assign rs1     = inst[9:5];
    assign rs2     = is_cond ? inst[4:0] : inst[14:10];
    assign rd      = bl_inst ? la_pkg::link_reg : inst[4:0];
    // Loads and stores fall out through legal
    assign wb_en   = legal & ~is_cond & ~b_inst & (rd != '0);

    ////////////////////
    // Immediates

    always_comb begin
        if (is_si12)                 imm = {{20{inst[21]}}, inst[21:10]};
        else if (is_ui12)            imm = {20'd0, inst[21:10]};
        else if (is_shi)             imm = {27'd0, inst[14:10]};
        else if (is_u12i)            imm = {inst[24:5], 12'd0};
        else if (is_cond | jirl_inst) imm = {{14{inst[25]}}, inst[25:10], 2'b00};
        else if (b_inst | bl_inst)   imm = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        else                         imm = '0;
    end

    always_comb begin
        if (sub_inst)                     alu_op = la_pkg::sub;
        else if (slt_inst | slti_inst)    alu_op = la_pkg::slt;
        else if (sltu_inst | sltui_inst)  alu_op = la_pkg::sltu;
        else if (and_inst | andi_inst)    alu_op = la_pkg::and_op;
        else if (nor_inst)                alu_op = la_pkg::nor_op;
        else if (or_inst | ori_inst)      alu_op = la_pkg::or_op;
        else if (xor_inst | xori_inst)    alu_op = la_pkg::xor_op;
        else if (sll_inst | slli_inst)    alu_op = la_pkg::sll;
        else if (srl_inst | srli_inst)    alu_op = la_pkg::srl;
        else if (sra_inst | srai_inst)    alu_op = la_pkg::sra;
        else                              alu_op = la_pkg::add;
    end

    always_comb begin
        if (beq_inst)       br_type = la_pkg::beq;
        else if (bne_inst)  br_type = la_pkg::bne;
        else if (blt_inst)  br_type = la_pkg::blt;
        else if (bge_inst)  br_type = la_pkg::bge;
        else if (bltu_inst) br_type = la_pkg::bltu;
        else if (bgeu_inst) br_type = la_pkg::bgeu;
        else if (b_inst)    br_type = la_pkg::b;
        else if (bl_inst)   br_type = la_pkg::bl;
        else if (jirl_inst) br_type = la_pkg::jirl;
        else                br_type = la_pkg::none;
    end

    // Link value is pc + 4 for bl and jirl
    always_comb begin
        if (pcaddu12i_inst | bl_inst | jirl_inst) src1_sel = la_pkg::src1_pc;
        else if (lu12i_inst)                      src1_sel = la_pkg::src1_zero;
        else                                      src1_sel = la_pkg::src1_rj;

        if (bl_inst | jirl_inst)                       src2_sel = la_pkg::src2_four;
        else if (is_si12 | is_ui12 | is_shi | is_u12i) src2_sel = la_pkg::src2_imm;
        else                                           src2_sel = la_pkg::src2_reg;
    end

endmodule

`default_nettype wire

// File: hw/la_execute.sv
`timescale 1ns/1ps
`default_nettype none

module la_execute (
    input  wire  [la_pkg::xlen-1:0] pc,
    input  wire  [la_pkg::xlen-1:0] rdata1,
    input  wire  [la_pkg::xlen-1:0] rdata2,
    input  wire  [la_pkg::xlen-1:0] imm,
    input  wire  la_pkg::alu_op_e   alu_op,
    input  wire  la_pkg::br_type_e  br_type,
    input  wire  la_pkg::src1_sel_e src1_sel,
    input  wire  la_pkg::src2_sel_e src2_sel,
    output logic [la_pkg::xlen-1:0] alu_result,
    output logic                    br_taken,
    output logic [la_pkg::xlen-1:0] br_target
);

    logic [la_pkg::xlen-1:0] op1;
    logic [la_pkg::xlen-1:0] op2;
    logic [4:0]              shamt;

    ////////////////////
    // Operand select

    always_comb begin
        case (src1_sel)
            la_pkg::src1_pc:   op1 = pc;
            la_pkg::src1_zero: op1 = '0;
            default:           op1 = rdata1;
        endcase
        case (src2_sel)
            la_pkg::src2_imm:  op2 = imm;
            la_pkg::src2_four: op2 = 32'd4;
            default:           op2 = rdata2;
        endcase
    end

    assign shamt = op2[4:0];

    ////////////////////
    // ALU

    always_comb begin
        case (alu_op)
            la_pkg::sub:    alu_result = op1 - op2;
            la_pkg::slt:    alu_result = {31'd0, $signed(op1) < $signed(op2)};
            la_pkg::sltu:   alu_result = {31'd0, op1 < op2};
            la_pkg::and_op: alu_result = op1 & op2;
            la_pkg::nor_op: alu_result = ~(op1 | op2);
            la_pkg::or_op:  alu_result = op1 | op2;
            la_pkg::xor_op: alu_result = op1 ^ op2;
            la_pkg::sll:    alu_result = op1 << shamt;
            la_pkg::srl:    alu_result = op1 >> shamt;
            la_pkg::sra:    alu_result = $signed(op1) >>> shamt;
            default:        alu_result = op1 + op2;
        endcase
    end

    // Conditional branches compare rj against rd
    always_comb begin
        case (br_type)
            la_pkg::beq:  br_taken = (rdata1 == rdata2);
            la_pkg::bne:  br_taken = (rdata1 != rdata2);
            la_pkg::blt:  br_taken = ($signed(rdata1) < $signed(rdata2));
            la_pkg::bge:  br_taken = ($signed(rdata1) >= $signed(rdata2));
            la_pkg::bltu: br_taken = (rdata1 < rdata2);
            la_pkg::bgeu: br_taken = (rdata1 >= rdata2);
            la_pkg::b, la_pkg::bl, la_pkg::jirl: br_taken = 1'b1;
            default:      br_taken = 1'b0;
        endcase
    end

    assign br_target = (br_type == la_pkg::jirl) ? rdata1 + imm : pc + imm;

endmodule

`default_nettype wire

// File: hw/la_issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module la_issue_ctrl (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       req,
    input  wire  [la_pkg::xlen-1:0]   inst,
    input  wire  [la_pkg::xlen-1:0]   pc,
    output logic                      ack,
    output logic                      exec_en,
    output logic [la_pkg::xlen-1:0]   inst_q,
    output logic [la_pkg::xlen-1:0]   pc_q
);

    la_pkg::issue_state_e state;

    // One cycle in exec per instruction
    assign exec_en = (state == la_pkg::exec);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= la_pkg::idle;
            ack   <= 1'b0;
        end else begin
            case (state)
                la_pkg::idle: begin
                    if (req) begin
                        state <= la_pkg::exec;
                    end
                end
                la_pkg::exec: begin
                    state <= la_pkg::done;
                end
                la_pkg::done: begin
                    // Hold results until the requester lets go
                    if (req) begin
                        ack <= 1'b1;
                    end else begin
                        ack   <= 1'b0;
                        state <= la_pkg::idle;
                    end
                end
                default: begin
                    state <= la_pkg::idle;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == la_pkg::idle && req) begin
            inst_q <= inst;
            pc_q   <= pc;
        end
    end

endmodule

`default_nettype wire

// File: hw/la_pkg.sv
`default_nettype none

package la_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int nregs      = 32;

    // bl writes its return address here
    localparam logic [reg_addr_w-1:0] link_reg = 5'd1;

    ////////////////////
    // Decode encodings

    typedef enum logic [3:0] {
        add, sub, slt, sltu,
        and_op, nor_op, or_op, xor_op,
        sll, srl, sra
    } alu_op_e;

    typedef enum logic [3:0] {
        none,
        beq, bne, blt, bge, bltu, bgeu,
        b, bl, jirl
    } br_type_e;

    typedef enum logic [1:0] {
        src1_rj,
        src1_pc,
        src1_zero
    } src1_sel_e;

    typedef enum logic [1:0] {
        src2_reg,
        src2_imm,
        src2_four
    } src2_sel_e;

    ////////////////////
    // Handshake FSM

    typedef enum logic [1:0] {
        idle,
        exec,
        done
    } issue_state_e;

endpackage

`default_nettype wire

// File: hw/la_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module la_regfile (
    input  wire                           clk,
    input  wire                           rst,
    input  wire  [la_pkg::reg_addr_w-1:0] rs1,
    input  wire  [la_pkg::reg_addr_w-1:0] rs2,
    output logic [la_pkg::xlen-1:0]       rdata1,
    output logic [la_pkg::xlen-1:0]       rdata2,
    input  wire                           we,
    input  wire  [la_pkg::reg_addr_w-1:0] waddr,
    input  wire  [la_pkg::xlen-1:0]       wdata
);

    logic [la_pkg::xlen-1:0] regs [la_pkg::nregs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < la_pkg::nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: hw/la_result.sv
`timescale 1ns/1ps
`default_nettype none

module la_result (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           exec_en,
    input  wire  [la_pkg::xlen-1:0]       alu_result,
    input  wire                           br_taken_in,
    input  wire  [la_pkg::xlen-1:0]       br_target_in,
    input  wire  [la_pkg::reg_addr_w-1:0] rd,
    input  wire                           wb_en_in,
    input  wire                           illegal_in,
    output logic                          wb_en,
    output logic [la_pkg::reg_addr_w-1:0] wb_addr,
    output logic [la_pkg::xlen-1:0]       wb_data,
    output logic                          br_taken,
    output logic [la_pkg::xlen-1:0]       br_target,
    output logic                          illegal,
    output logic                          rf_we,
    output logic [la_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [la_pkg::xlen-1:0]       rf_wdata
);

    // Register file write happens in the exec cycle itself
    assign rf_we    = exec_en & wb_en_in;
    assign rf_waddr = rd;
    assign rf_wdata = alu_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_en    <= 1'b0;
            br_taken <= 1'b0;
            illegal  <= 1'b0;
        end else if (exec_en) begin
            wb_en    <= wb_en_in;
            br_taken <= br_taken_in;
            illegal  <= illegal_in;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_en) begin
            wb_addr   <= rd;
            wb_data   <= alu_result;
            br_target <= br_target_in;
        end
    end

endmodule

`default_nettype wire

// File: list.f
hw/la_pkg.sv
hw/la_issue_ctrl.sv
hw/la_decode.sv
hw/la_regfile.sv
hw/la_execute.sv
hw/la_result.sv
hw/la_core.sv
bench/la_core_tb.sv
